// File: design/cpu_bus_consts.svh
// ----------------------------------------------------------
// CPU bus constants.
// Widths, full lane mask and byte order default.
// ----------------------------------------------------------

`ifndef CPU_BUS_CONSTS_SVH
`define CPU_BUS_CONSTS_SVH

// Bus widths.
`define CPU_BUS_ADDR_W          32
`define CPU_BUS_DATA_W          32
`define CPU_BUS_SEL_W           4

// All byte lanes on, used for word fetches.
`define CPU_BUS_SEL_ALL         4'b1111

// Data port runs big endian (BE-32) by default.
`define CPU_BUS_BE32_DEFAULT    1'b1

`endif

// File: design/cpu_bus_pkg.sv
// ----------------------------------------------------------
// CPU bus types.
// Vector types and the arbiter state encoding.
// ----------------------------------------------------------

`default_nettype none

`include "cpu_bus_consts.svh"

package cpu_bus_pkg;

        typedef logic [`CPU_BUS_ADDR_W-1:0] addr_t;     // Byte address.
        typedef logic [`CPU_BUS_DATA_W-1:0] data_t;     // One bus word.
        typedef logic [`CPU_BUS_SEL_W-1:0]  sel_t;      // Byte lane enables.

        // Owner of the shared master.
        typedef enum logic [1:0]
        {
                ARB_IDLE = 2'd0,
                ARB_CODE = 2'd1,
                ARB_DATA = 2'd2
        } arb_state_t;

endpackage

`default_nettype wire

// File: design/bus_req_if.sv
// ----------------------------------------------------------
// Request interface between one port and the arbiter.
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "cpu_bus_consts.svh"

interface bus_req_if
        import cpu_bus_pkg::*;
();

        logic   req_valid;      // Request held by the port.
        logic   we;             // Store when high.
        addr_t  adr;
        sel_t   sel;
        data_t  wdat;

        logic   req_ready;      // Arbiter takes the request.
        logic   rsp_valid;      // Single cycle, never stalled.
        data_t  rdat;

        modport requester
        (
                output req_valid, we, adr, sel, wdat,
                input  req_ready, rsp_valid, rdat
        );

        modport arbiter
        (
                input  req_valid, we, adr, sel, wdat,
                output req_ready, rsp_valid, rdat
        );

endinterface

`default_nettype wire

// File: design/code_port.sv
// ----------------------------------------------------------
// Instruction fetch port.
// Holds one word aligned fetch until its response returns.
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "cpu_bus_consts.svh"

module code_port
        import cpu_bus_pkg::*;
(
        input  logic            i_clk,
        input  logic            i_rst_n,

        // Fetch request.
        input  logic            i_code_valid,
        output logic            o_code_ready,
        input  addr_t           i_code_adr,

        // Fetch response.
        output logic            o_code_rsp_valid,
        output data_t           o_code_rdat,

        bus_req_if.requester    bus
);

logic   full_q;         // A fetch is held.
logic   pend_q;         // Not yet taken by the arbiter.
addr_t  adr_q;
logic   accept;
logic   issued;

assign accept       = i_code_valid && !full_q;
assign issued       = pend_q && bus.req_ready;
assign o_code_ready = !full_q;

always_ff @(posedge i_clk or negedge i_rst_n)
begin
        if (!i_rst_n)
        begin
                full_q           <= 1'b0;
                pend_q           <= 1'b0;
                o_code_rsp_valid <= 1'b0;
        end
        else
        begin
                o_code_rsp_valid <= bus.rsp_valid;

                if (accept)
                        full_q <= 1'b1;
                else if (bus.rsp_valid)
                        full_q <= 1'b0; // Free again with the response.

                if (accept)
                        pend_q <= 1'b1;
                else if (issued)
                        pend_q <= 1'b0;
        end
end

always_ff @(posedge i_clk)
begin
        if (accept)
                adr_q <= {i_code_adr[`CPU_BUS_ADDR_W-1:2], 2'b00}; // Word aligned.

        if (bus.rsp_valid)
                o_code_rdat <= bus.rdat;
end

// Fetches are full word reads.
assign bus.req_valid = pend_q;
assign bus.we        = 1'b0;
assign bus.adr       = adr_q;
assign bus.sel       = `CPU_BUS_SEL_ALL;
assign bus.wdat      = '0;

endmodule

`default_nettype wire

// File: design/data_port.sv
// ----------------------------------------------------------
// Load/store port.
// Holds one access and applies BE-32 lane reversal.
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "cpu_bus_consts.svh"

module data_port
        import cpu_bus_pkg::*;
#(
        parameter logic [0:0] BE_32_ENABLE = `CPU_BUS_BE32_DEFAULT
)
(
        input  logic            i_clk,
        input  logic            i_rst_n,

        // Load/store request.
        input  logic            i_data_valid,
        output logic            o_data_ready,
        input  logic            i_data_we,
        input  addr_t           i_data_adr,
        input  sel_t            i_data_sel,
        input  data_t           i_data_wdat,

        // Load/store response.
        output logic            o_data_rsp_valid,
        output data_t           o_data_rdat,

        bus_req_if.requester    bus
);

// ----------------------------------------------------------
// Lane reversal helpers.
// ----------------------------------------------------------

function automatic sel_t swap_sel(input sel_t s);
        sel_t r;
        for (int k = 0; k < `CPU_BUS_SEL_W; k++)
                r[k] = s[`CPU_BUS_SEL_W-1-k];
        return r;
endfunction

function automatic data_t swap_bytes(input data_t d);
        data_t r;
        for (int k = 0; k < `CPU_BUS_SEL_W; k++)
                r[8*k +: 8] = d[8*(`CPU_BUS_SEL_W-1-k) +: 8];
        return r;
endfunction

logic   full_q;
logic   pend_q;
logic   we_q;
addr_t  adr_q;
sel_t   sel_q;
data_t  wdat_q;
logic   accept;
logic   issued;
sel_t   lane_sel;
data_t  lane_wdat;
data_t  lane_rdat;

assign accept       = i_data_valid && !full_q;
assign issued       = pend_q && bus.req_ready;
assign o_data_ready = !full_q;

// Byte order applied once here.
assign lane_sel  = BE_32_ENABLE ? swap_sel(i_data_sel)    : i_data_sel;
assign lane_wdat = BE_32_ENABLE ? swap_bytes(i_data_wdat) : i_data_wdat;
assign lane_rdat = BE_32_ENABLE ? swap_bytes(bus.rdat)    : bus.rdat;

always_ff @(posedge i_clk or negedge i_rst_n)
begin
        if (!i_rst_n)
        begin
                full_q           <= 1'b0;
                pend_q           <= 1'b0;
                o_data_rsp_valid <= 1'b0;
        end
        else
        begin
                o_data_rsp_valid <= bus.rsp_valid;

                if (accept)
                        full_q <= 1'b1;
                else if (bus.rsp_valid)
                        full_q <= 1'b0;

                if (accept)
                        pend_q <= 1'b1;
                else if (issued)
                        pend_q <= 1'b0; // Arbiter owns it now.
        end
end

always_ff @(posedge i_clk)
begin
        if (accept)
        begin
                we_q   <= i_data_we;
                adr_q  <= i_data_adr;
                sel_q  <= lane_sel;
                wdat_q <= lane_wdat;
        end

        if (bus.rsp_valid)
                o_data_rdat <= lane_rdat;
end

assign bus.req_valid = pend_q;
assign bus.we        = we_q;
assign bus.adr       = adr_q;
assign bus.sel       = sel_q;
assign bus.wdat      = wdat_q;

endmodule

`default_nettype wire

// File: design/wb_arbiter.sv
// ----------------------------------------------------------
// Wishbone arbiter.
// Shares one classic master between fetch and data ports.
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "cpu_bus_consts.svh"

module wb_arbiter
        import cpu_bus_pkg::*;
(
        input  logic            i_clk,
        input  logic            i_rst_n,

        bus_req_if.arbiter      code,
        bus_req_if.arbiter      data,

        // Wishbone master.
        output logic            o_wb_cyc,
        output logic            o_wb_stb,
        output logic            o_wb_we,
        output addr_t           o_wb_adr,
        output sel_t            o_wb_sel,
        output data_t           o_wb_dat,
        input  logic            i_wb_ack,
        input  data_t           i_wb_dat
);

arb_state_t     state_q;
arb_state_t     state_nxt;
logic           grant_code;
logic           grant_data;
logic           grant;
logic           ack_done;
logic           code_rsp_q;
logic           data_rsp_q;
data_t          rdat_q;

// Selected request.
logic           req_we;
addr_t          req_adr;
sel_t           req_sel;
data_t          req_wdat;

// ----------------------------------------------------------
// Grant, data port first.
// ----------------------------------------------------------

assign grant_data = (state_q == ARB_IDLE) && data.req_valid;
assign grant_code = (state_q == ARB_IDLE) && code.req_valid && !data.req_valid;
assign grant      = grant_data || grant_code;
assign ack_done   = o_wb_cyc && i_wb_ack;

assign data.req_ready = grant_data;
assign code.req_ready = grant_code;

assign req_we   = grant_data ? data.we   : code.we;
assign req_adr  = grant_data ? data.adr  : code.adr;
assign req_sel  = grant_data ? data.sel  : code.sel;
assign req_wdat = grant_data ? data.wdat : code.wdat;

always_comb
begin
        state_nxt = state_q;

        case (state_q)
        ARB_IDLE:
        begin
                if (grant_data)
                        state_nxt = ARB_DATA;
                else if (grant_code)
                        state_nxt = ARB_CODE;
        end
        ARB_CODE, ARB_DATA:
        begin
                if (ack_done)
                        state_nxt = ARB_IDLE;
        end
        default: state_nxt = ARB_IDLE;
        endcase
end

// ----------------------------------------------------------
// Bus control and response pulses.
// ----------------------------------------------------------

always_ff @(posedge i_clk or negedge i_rst_n)
begin
        if (!i_rst_n)
        begin
                state_q    <= ARB_IDLE;
                o_wb_cyc   <= 1'b0;
                o_wb_stb   <= 1'b0;
                o_wb_we    <= 1'b0;
                code_rsp_q <= 1'b0;
                data_rsp_q <= 1'b0;
        end
        else
        begin
                state_q    <= state_nxt;
                code_rsp_q <= ack_done && (state_q == ARB_CODE);
                data_rsp_q <= ack_done && (state_q == ARB_DATA);

                if (grant)
                begin
                        o_wb_cyc <= 1'b1;
                        o_wb_stb <= 1'b1;
                        o_wb_we  <= req_we;
                end
                else if (ack_done)
                begin
                        o_wb_cyc <= 1'b0; // Single classic cycle.
                        o_wb_stb <= 1'b0;
                        o_wb_we  <= 1'b0;
                end
        end
end

always_ff @(posedge i_clk)
begin
        if (grant)
        begin
                o_wb_adr <= req_adr;
                o_wb_sel <= req_sel;
                o_wb_dat <= req_wdat;
        end

        if (ack_done)
                rdat_q <= i_wb_dat;     // Read word for the owner.
end

assign code.rsp_valid = code_rsp_q;
assign data.rsp_valid = data_rsp_q;
assign code.rdat      = rdat_q;
assign data.rdat      = rdat_q;

endmodule

`default_nettype wire

// File: design/cpu_bus_top.sv
// ----------------------------------------------------------
// CPU memory bus top level.
// Fetch and load/store ports sharing one Wishbone master.
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "cpu_bus_consts.svh"

module cpu_bus_top
        import cpu_bus_pkg::*;
(
        // ----------------------------------------------------------
        // Clock and reset.
        // ----------------------------------------------------------

        input  logic    i_clk,
        input  logic    i_rst_n,

        // ----------------------------------------------------------
        // Instruction fetch.
        // ----------------------------------------------------------

        input  logic    i_code_valid,
        output logic    o_code_ready,
        input  addr_t   i_code_adr,
        output logic    o_code_rsp_valid,
        output data_t   o_code_rdat,

        // ----------------------------------------------------------
        // Load/store.
        // ----------------------------------------------------------

        input  logic    i_data_valid,
        output logic    o_data_ready,
        input  logic    i_data_we,
        input  addr_t   i_data_adr,
        input  sel_t    i_data_sel,
        input  data_t   i_data_wdat,
        output logic    o_data_rsp_valid,
        output data_t   o_data_rdat,

        // ----------------------------------------------------------
        // Wishbone master.
        // ----------------------------------------------------------

        output logic    o_wb_cyc,
        output logic    o_wb_stb,
        output logic    o_wb_we,
        output addr_t   o_wb_adr,
        output sel_t    o_wb_sel,
        output data_t   o_wb_dat,
        input  logic    i_wb_ack,
        input  data_t   i_wb_dat
);

bus_req_if code_bus ();         // Fetch side.
bus_req_if data_bus ();         // Load/store side.

code_port u_code_port
(
        .i_clk                  (i_clk),
        .i_rst_n                (i_rst_n),
        .i_code_valid           (i_code_valid),
        .o_code_ready           (o_code_ready),
        .i_code_adr             (i_code_adr),
        .o_code_rsp_valid       (o_code_rsp_valid),
        .o_code_rdat            (o_code_rdat),
        .bus                    (code_bus)
);

data_port #(
        .BE_32_ENABLE           (`CPU_BUS_BE32_DEFAULT)
) u_data_port
(
        .i_clk                  (i_clk),
        .i_rst_n                (i_rst_n),
        .i_data_valid           (i_data_valid),
        .o_data_ready           (o_data_ready),
        .i_data_we              (i_data_we),
        .i_data_adr             (i_data_adr),
        .i_data_sel             (i_data_sel),
        .i_data_wdat            (i_data_wdat),
        .o_data_rsp_valid       (o_data_rsp_valid),
        .o_data_rdat            (o_data_rdat),
        .bus                    (data_bus)
);

wb_arbiter u_wb_arbiter
(
        .i_clk                  (i_clk),
        .i_rst_n                (i_rst_n),
        .code                   (code_bus),
        .data                   (data_bus),
        .o_wb_cyc               (o_wb_cyc),
        .o_wb_stb               (o_wb_stb),
        .o_wb_we                (o_wb_we),
        .o_wb_adr               (o_wb_adr),
        .o_wb_sel               (o_wb_sel),
        .o_wb_dat               (o_wb_dat),
        .i_wb_ack               (i_wb_ack),
        .i_wb_dat               (i_wb_dat)
);

endmodule

`default_nettype wire

// File: tb/tb_cpu_bus_top.sv
// ----------------------------------------------------------
// Testbench for the CPU memory bus top level.
// Directed tests against a Wishbone slave memory model.
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "cpu_bus_consts.svh"

module tb_cpu_bus_top
        import cpu_bus_pkg::*;
();

localparam int NUM_TESTS = 5;

logic   i_clk;
logic   i_rst_n;
logic   i_code_valid;
logic   o_code_ready;
addr_t  i_code_adr;
logic   o_code_rsp_valid;
data_t  o_code_rdat;
logic   i_data_valid;
logic   o_data_ready;
logic   i_data_we;
addr_t  i_data_adr;
sel_t   i_data_sel;
data_t  i_data_wdat;
logic   o_data_rsp_valid;
data_t  o_data_rdat;
logic   o_wb_cyc;
logic   o_wb_stb;
logic   o_wb_we;
addr_t  o_wb_adr;
sel_t   o_wb_sel;
data_t  o_wb_dat;
logic   i_wb_ack;
data_t  i_wb_dat;

data_t  mem [0:255];            // Slave memory, word indexed.

cpu_bus_top dut0 (.*);

initial
begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
end

// ----------------------------------------------------------
// Checks.
// ----------------------------------------------------------

task automatic report_mismatch(input string name, input data_t exp, input data_t act);
        $display("[ERROR] t=%0t %s expected 0x%h actual 0x%h", $time, name, exp, act);
        $display("FAIL: see errors above");
        $fatal(1, "Stopping on the first mismatch.");
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
        assert (act === exp) else report_mismatch(name, 32'(exp), 32'(act));
endtask

task automatic check_word(input string name, input data_t exp, input data_t act);
        assert (act === exp) else report_mismatch(name, exp, act);
endtask

// ----------------------------------------------------------
// Wishbone slave model with 0 to 3 extra wait cycles.
// ----------------------------------------------------------

initial
begin
        logic   busy;
        int     wait_cnt;

        void'($urandom(11012));
        busy     = 1'b0;
        wait_cnt = 0;
        i_wb_ack <= 1'b0;
        i_wb_dat <= '0;
        for (int i = 0; i < 256; i++)
                mem[i] = 32'(i) * 32'h9E37_79B9 + 32'h0BAD_F00D;
        forever
        begin
                @(posedge i_clk);
                i_wb_ack <= 1'b0;
                if (o_wb_cyc && o_wb_stb && !i_wb_ack)
                begin
                        if (!busy)
                        begin
                                busy     = 1'b1;
                                wait_cnt = int'($urandom % 4);
                        end
                        if (wait_cnt != 0)
                                wait_cnt = wait_cnt - 1;
                        else
                        begin
                                busy = 1'b0;
                                i_wb_ack <= 1'b1;
                                i_wb_dat <= mem[o_wb_adr[9:2]];
                                for (int k = 0; k < 4; k++)
                                        if (o_wb_we && o_wb_sel[k])
                                                mem[o_wb_adr[9:2]][8*k +: 8] = o_wb_dat[8*k +: 8];
                        end
                end
        end
end

// Bus must hold its request until the ack.
always @(negedge i_clk)
begin
        static logic  held = 1'b0;
        static addr_t held_adr = '0;
        static sel_t  held_sel = '0;
        static data_t held_dat = '0;

        if (i_rst_n && held)
        begin
                check_bit("o_wb_cyc", 1'b1, o_wb_cyc);
                check_bit("o_wb_stb", 1'b1, o_wb_stb);
                check_word("o_wb_adr", held_adr, o_wb_adr);
                check_word("o_wb_sel", 32'(held_sel), 32'(o_wb_sel));
                check_word("o_wb_dat", held_dat, o_wb_dat);
        end
        held     = o_wb_cyc && !i_wb_ack;
        held_adr = o_wb_adr;
        held_sel = o_wb_sel;
        held_dat = o_wb_dat;
end

initial
begin
        repeat (16 + 200 * NUM_TESTS) @(posedge i_clk);
        $display("FAIL: see errors above");
        $fatal(1, "Timeout: the DUT did not respond within the test time limit.");
end

// ----------------------------------------------------------
// Request and response helpers.
// ----------------------------------------------------------

task automatic issue_code(input addr_t adr);
        @(negedge i_clk);
        check_bit("o_code_ready", 1'b1, o_code_ready);
        @(posedge i_clk);
        i_code_valid <= 1'b1;
        i_code_adr   <= adr;
        @(posedge i_clk);               // Accepted here.
        i_code_valid <= 1'b0;
        @(negedge i_clk);
        check_bit("o_code_ready", 1'b0, o_code_ready);
endtask

task automatic issue_data(input logic we, input addr_t adr, input sel_t sel, input data_t wdat);
        @(negedge i_clk);
        check_bit("o_data_ready", 1'b1, o_data_ready);
        @(posedge i_clk);
        i_data_valid <= 1'b1;
        i_data_we    <= we;
        i_data_adr   <= adr;
        i_data_sel   <= sel;
        i_data_wdat  <= wdat;
        @(posedge i_clk);
        i_data_valid <= 1'b0;
        @(negedge i_clk);
        check_bit("o_data_ready", 1'b0, o_data_ready);
endtask

task automatic wait_bus_request(input logic we, input addr_t adr, input sel_t sel);
        while (!o_wb_cyc)
                @(negedge i_clk);
        check_bit("o_wb_we", we, o_wb_we);
        check_word("o_wb_adr", adr, o_wb_adr);
        check_word("o_wb_sel", 32'(sel), 32'(o_wb_sel));
endtask

task automatic wait_code_response();
        while (!o_code_rsp_valid)
        begin
                check_bit("o_code_ready", 1'b0, o_code_ready);
                @(negedge i_clk);
        end
        check_bit("o_code_ready", 1'b1, o_code_ready);
endtask

task automatic wait_data_response();
        while (!o_data_rsp_valid)
        begin
                check_bit("o_data_ready", 1'b0, o_data_ready);
                @(negedge i_clk);
        end
        check_bit("o_data_ready", 1'b1, o_data_ready);
endtask

function automatic data_t reverse_bytes(input data_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
endfunction

// ----------------------------------------------------------
// Tests.
// ----------------------------------------------------------

task automatic check_idle_outputs();
        check_bit("o_wb_cyc", 1'b0, o_wb_cyc);
        check_bit("o_wb_stb", 1'b0, o_wb_stb);
        check_bit("o_code_rsp_valid", 1'b0, o_code_rsp_valid);
        check_bit("o_data_rsp_valid", 1'b0, o_data_rsp_valid);
        check_bit("o_code_ready", 1'b1, o_code_ready);
        check_bit("o_data_ready", 1'b1, o_data_ready);
endtask

task automatic test_reset();
        @(posedge i_clk);
        repeat (16)
        begin
                @(negedge i_clk);
                check_idle_outputs();
        end
        @(posedge i_clk);
        i_rst_n <= 1'b1;
        repeat (2)
        begin
                @(negedge i_clk);
                check_idle_outputs();
        end
endtask

task automatic test_fetch();
        issue_code(32'h0000_0013);      // Low bits 2'b11.
        wait_bus_request(1'b0, 32'h0000_0010, `CPU_BUS_SEL_ALL);
        wait_code_response();
        check_word("o_code_rdat", mem[4], o_code_rdat);
endtask

task automatic test_store();
        data_t old;

        old = mem[16];
        issue_data(1'b1, 32'h0000_0040, 4'b0001, 32'hA1B2_C3D4);
        wait_bus_request(1'b1, 32'h0000_0040, 4'b1000);
        check_word("o_wb_dat", 32'hD4C3_B2A1, o_wb_dat);
        wait_data_response();
        check_word("mem[16]", {8'hD4, old[23:0]}, mem[16]);
endtask

task automatic test_load();
        data_t known;

        known = mem[16];
        issue_data(1'b0, 32'h0000_0040, 4'b1111, '0);
        wait_bus_request(1'b0, 32'h0000_0040, 4'b1111);
        wait_data_response();
        check_word("o_data_rdat", reverse_bytes(known), o_data_rdat);
endtask

task automatic test_contention();
        logic   seen_cyc;
        logic   code_done;
        logic   data_done;

        seen_cyc  = 1'b0;
        code_done = 1'b0;
        data_done = 1'b0;
        @(negedge i_clk);
        check_idle_outputs();
        @(posedge i_clk);
        i_code_valid <= 1'b1;
        i_code_adr   <= 32'h0000_0024;
        i_data_valid <= 1'b1;
        i_data_we    <= 1'b0;
        i_data_adr   <= 32'h0000_0030;
        i_data_sel   <= 4'b1111;
        @(posedge i_clk);               // Both ports accept.
        i_code_valid <= 1'b0;
        i_data_valid <= 1'b0;
        while (!(code_done && data_done))
        begin
                @(negedge i_clk);
                if (o_wb_cyc && !seen_cyc)
                begin
                        seen_cyc = 1'b1;        // Data port wins.
                        check_word("o_wb_adr", 32'h0000_0030, o_wb_adr);
                end
                if (o_data_rsp_valid)
                begin
                        data_done = 1'b1;
                        check_bit("code response before data", 1'b0, code_done);
                        check_word("o_data_rdat", reverse_bytes(mem[12]), o_data_rdat);
                end
                else if (!data_done)
                        check_bit("o_data_ready", 1'b0, o_data_ready);
                if (o_code_rsp_valid)
                begin
                        code_done = 1'b1;
                        check_word("o_code_rdat", mem[9], o_code_rdat);
                end
                else if (!code_done)
                        check_bit("o_code_ready", 1'b0, o_code_ready);
        end
endtask

initial
begin
        i_rst_n      <= 1'b0;
        i_code_valid <= 1'b0;
        i_code_adr   <= '0;
        i_data_valid <= 1'b0;
        i_data_we    <= 1'b0;
        i_data_adr   <= '0;
        i_data_sel   <= '0;
        i_data_wdat  <= '0;
        test_reset();
        test_fetch();
        test_store();
        test_load();
        test_contention();
        $display("PASS: all tests");
        $finish;
end

endmodule

`default_nettype wire

// File: project.f
+incdir+design
design/cpu_bus_pkg.sv
design/bus_req_if.sv
design/code_port.sv
design/data_port.sv
design/wb_arbiter.sv
design/cpu_bus_top.sv
tb/tb_cpu_bus_top.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_cpu_bus_top
FILELIST  = project.f
OBJDIR    = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
